// ==== design/game_pkg.sv ====
// shared constants, field widths and bus structs for the game control core
// every design file refers to these by scoped names

package game_pkg;

	// ==============================
	// score
	// ==============================
	localparam int SCORE_DIGITS = 6;
	// carry out of this digit means another 10000 points
	localparam int BONUS_DIGIT = 3;
	typedef logic [SCORE_DIGITS-1:0][3:0] score_t;

	// ==============================
	// lives
	// ==============================
	localparam int NUM_LIVES = 3;
	localparam int MAX_LIVES = 10;
	typedef logic [$clog2(MAX_LIVES+1)-1:0] lives_t;

	// ==============================
	// frame timing and sequencing
	// ==============================
	localparam int ANIM_FRAMES = 12;
	localparam int TORPEDO_PHASES = 3;
	localparam int INTRO_FRAMES = 256;
	localparam int WAVE_FRAMES = 512;
	typedef logic [$clog2(ANIM_FRAMES)-1:0] anim_cnt_t;
	typedef logic [$clog2(TORPEDO_PHASES)-1:0] anim_phase_t;
	typedef logic [$clog2(WAVE_FRAMES)-1:0] wave_cnt_t;

	// ==============================
	// host port
	// ==============================
	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 32;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h0;
	localparam logic [APB_ADDR_W-1:0] ADDR_SCORE = 4'h4;
	localparam logic [APB_ADDR_W-1:0] ADDR_POINTS = 4'h8;
	localparam logic [APB_ADDR_W-1:0] ADDR_COLLIDE = 4'hc;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic [APB_DATA_W-1:0] prdata;
		logic pslverr;
	} apb_rsp_t;

	// field order matches the STATUS register, game_over lands in bit 0
	typedef struct packed {
		lives_t lives;
		logic start_done;
		logic game_continue;
		logic game_begin;
		logic game_over;
	} game_status_t;

endpackage

// ==== design/frame_timer.sv ====
// frame strobe from vsync plus the shared sprite animation pulse
// anim_phase drives the three-step torpedo animation

module frame_timer (
	input logic clk_25,
	input logic resetN,
	input logic vsync,
	output logic frame,
	output logic anim_pulse,
	output game_pkg::anim_phase_t anim_phase
);

	logic vsync_d;
	game_pkg::anim_cnt_t anim_cnt;

	// ==============================
	// vsync edge and animation divider
	// ==============================
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			vsync_d <= 1'b0;
			frame <= 1'b0;
			anim_cnt <= '0;
			anim_pulse <= 1'b0;
		end else begin
			vsync_d <= vsync;
			// one strobe per frame, on the low to high edge
			frame <= vsync && !vsync_d;
			anim_pulse <= 1'b0;
			if (frame) begin
				// counter starts at zero so the first frame already pulses
				if (anim_cnt != '0) begin
					anim_cnt <= anim_cnt - 1'b1;
				end else begin
					anim_cnt <= game_pkg::anim_cnt_t'(game_pkg::ANIM_FRAMES - 1);
					anim_pulse <= 1'b1;
				end
			end
		end
	end

	// ==============================
	// torpedo animation phase
	// ==============================
	// counts down 2, 1, 0 and wraps, one step per pulse
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			anim_phase <= '0;
		end else if (anim_pulse) begin
			if (anim_phase != '0) begin
				anim_phase <= anim_phase - 1'b1;
			end else begin
				anim_phase <= game_pkg::anim_phase_t'(game_pkg::TORPEDO_PHASES - 1);
			end
		end
	end

endmodule

// ==== design/wave_sequencer.sv ====
// opening screen and new-wave delay, counted in frames
// also qualifies host collisions against the current game phase

module wave_sequencer (
	input logic clk_25,
	input logic resetN,
	input logic frame,
	input logic collision,
	input logic game_over,
	output logic life_lost,
	output logic start_done,
	output logic game_begin,
	output logic game_continue,
	output logic new_level
);

	game_pkg::wave_cnt_t wave_cnt;
	logic game_begin_d;
	logic hit;

	// collisions only count during play and before game over
	assign hit = collision && game_begin && !game_over;

	// ==============================
	// frame counter and phase flags
	// ==============================
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			wave_cnt <= '0;
			start_done <= 1'b0;
			game_begin <= 1'b0;
			game_continue <= 1'b0;
			life_lost <= 1'b0;
		end else begin
			life_lost <= hit;
			if (hit) begin
				// restart the wave delay halfway, opening screen is skipped
				wave_cnt <= game_pkg::wave_cnt_t'(game_pkg::INTRO_FRAMES - 1);
				game_continue <= 1'b0;
			end else if (frame) begin
				// saturating count
				if (wave_cnt != game_pkg::wave_cnt_t'(game_pkg::WAVE_FRAMES - 1)) begin
					wave_cnt <= wave_cnt + 1'b1;
				end
				// end of opening screen
				if (wave_cnt == game_pkg::wave_cnt_t'(game_pkg::INTRO_FRAMES - 1)) begin
					start_done <= 1'b1;
				end
				if (wave_cnt == game_pkg::wave_cnt_t'(game_pkg::WAVE_FRAMES - 1)) begin
					game_begin <= 1'b1;
					game_continue <= 1'b1;
				end else if (game_begin &&
						wave_cnt == game_pkg::wave_cnt_t'(game_pkg::WAVE_FRAMES - 2)) begin
					// wave delay done once the counter saturates on this frame
					game_continue <= 1'b1;
				end
			end
		end
	end

	// ==============================
	// new level pulse
	// ==============================
	// fires on the first frame that sees game_begin high
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			game_begin_d <= 1'b0;
			new_level <= 1'b0;
		end else begin
			new_level <= frame && game_begin && !game_begin_d;
			if (frame) begin
				game_begin_d <= game_begin;
			end
		end
	end

endmodule

// ==== design/lives_counter.sv ====
// lives bookkeeping: loss on collision, bonus life from the score
// game_over stays set until reset

module lives_counter (
	input logic clk_25,
	input logic resetN,
	input logic life_lost,
	input logic bonus,
	output game_pkg::lives_t lives,
	output logic game_over
);

	logic last_life;
	logic room_for_bonus;

	assign last_life = (lives == game_pkg::lives_t'(1));
	// cap at the maximum, and no extra lives once the game is over
	assign room_for_bonus = !game_over && (lives < game_pkg::lives_t'(game_pkg::MAX_LIVES));

	// ==============================
	// lives register
	// ==============================
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			lives <= game_pkg::lives_t'(game_pkg::NUM_LIVES);
			game_over <= 1'b0;
		end else if (life_lost) begin
			// a bonus in the same cycle is dropped
			if (lives != '0) begin
				lives <= lives - 1'b1;
			end
			if (last_life) begin
				game_over <= 1'b1;
			end
		end else if (bonus && room_for_bonus) begin
			lives <= lives + 1'b1;
		end
	end

endmodule

// ==== design/bcd_score.sv ====
// BCD score accumulator, one adder stage per decimal digit
// the carry out of BONUS_DIGIT flags a bonus life

module bcd_score (
	input logic clk_25,
	input logic resetN,
	input logic points_add,
	input game_pkg::score_t points,
	output game_pkg::score_t score,
	output logic bonus
);

	// carry[i] enters digit i, carry[SCORE_DIGITS] falls off the top
	logic [game_pkg::SCORE_DIGITS:0] carry;
	logic [game_pkg::SCORE_DIGITS-1:0][4:0] digit_sum;
	game_pkg::score_t sum;

	// ==============================
	// decimal ripple adder
	// ==============================
	always_comb begin
		carry[0] = 1'b0;
		for (int i = 0; i < game_pkg::SCORE_DIGITS; i++) begin
			// binary sum of two digits and carry is at most 19
			digit_sum[i] = {1'b0, score[i]} + {1'b0, points[i]} + {4'b0, carry[i]};
			if (digit_sum[i] > 5'd9) begin
				// decimal adjust
				sum[i] = 4'(digit_sum[i] - 5'd10);
				carry[i+1] = 1'b1;
			end else begin
				sum[i] = digit_sum[i][3:0];
				carry[i+1] = 1'b0;
			end
		end
	end

	// ==============================
	// score register
	// ==============================
	// past 999999 the score simply wraps
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			score <= '0;
			bonus <= 1'b0;
		end else begin
			bonus <= points_add && carry[game_pkg::BONUS_DIGIT+1];
			if (points_add) begin
				score <= sum;
			end
		end
	end

endmodule

// ==== design/apb_regs.sv ====
// APB slave for the host: event writes in, status and score reads out
// zero wait states, errors on unmapped offsets and read-only writes

module apb_regs (
	input logic clk_25,
	input logic resetN,
	input game_pkg::apb_req_t req,
	output game_pkg::apb_rsp_t rsp,
	input game_pkg::game_status_t status,
	input game_pkg::score_t score,
	output logic points_add,
	output game_pkg::score_t points,
	output logic collision
);

	logic access;
	logic sel_status;
	logic sel_score;
	logic sel_points;
	logic sel_collide;
	logic mapped;
	logic read_only;

	// ==============================
	// address decode
	// ==============================
	// transfer completes in the access phase, pready never drops
	assign access = req.psel && req.penable;
	assign sel_status = (req.paddr == game_pkg::ADDR_STATUS);
	assign sel_score = (req.paddr == game_pkg::ADDR_SCORE);
	assign sel_points = (req.paddr == game_pkg::ADDR_POINTS);
	assign sel_collide = (req.paddr == game_pkg::ADDR_COLLIDE);
	assign mapped = sel_status || sel_score || sel_points || sel_collide;
	assign read_only = sel_status || sel_score;

	// ==============================
	// read path and response
	// ==============================
	always_comb begin
		rsp.pready = 1'b1;
		rsp.pslverr = access && (!mapped || (req.pwrite && read_only));
		// points and collide are write-only and read back as zero
		rsp.prdata = '0;
		if (sel_status) begin
			rsp.prdata[$bits(game_pkg::game_status_t)-1:0] = status;
		end else if (sel_score) begin
			rsp.prdata[$bits(game_pkg::score_t)-1:0] = score;
		end
	end

	// ==============================
	// event strobes
	// ==============================
	always_ff @(posedge clk_25 or negedge resetN) begin
		if (!resetN) begin
			points_add <= 1'b0;
			collision <= 1'b0;
		end else begin
			points_add <= access && req.pwrite && sel_points;
			// only bit 0 of the collide write reports a hit
			collision <= access && req.pwrite && sel_collide && req.pwdata[0];
		end
	end

	// points value travels with the strobe
	always_ff @(posedge clk_25) begin
		if (access && req.pwrite && sel_points) begin
			points <= req.pwdata[$bits(game_pkg::score_t)-1:0];
		end
	end

endmodule

// ==== design/game_ctrl_top.sv ====
// top level of the game control core
// host talks APB, vsync paces the frames

module game_ctrl_top (
	input logic clk_25,
	input logic resetN,
	input logic vsync,
	input game_pkg::apb_req_t apb_req,
	output game_pkg::apb_rsp_t apb_rsp,
	output logic anim_pulse,
	output game_pkg::anim_phase_t anim_phase,
	output logic new_level,
	output game_pkg::game_status_t status
);

	// frame and host events
	logic frame;
	logic collision;
	logic points_add;
	game_pkg::score_t points;

	// game state
	logic life_lost;
	logic bonus;
	logic start_done;
	logic game_begin;
	logic game_continue;
	logic game_over;
	game_pkg::lives_t lives;
	game_pkg::score_t score;

	// ==============================
	// status word for the host
	// ==============================
	assign status = '{
		lives: lives,
		start_done: start_done,
		game_continue: game_continue,
		game_begin: game_begin,
		game_over: game_over
	};

	// ==============================
	// control blocks
	// ==============================
	frame_timer frame_timer_inst (
		.clk_25(clk_25),
		.resetN(resetN),
		.vsync(vsync),
		.frame(frame),
		.anim_pulse(anim_pulse),
		.anim_phase(anim_phase)
	);

	wave_sequencer wave_sequencer_inst (
		.clk_25(clk_25),
		.resetN(resetN),
		.frame(frame),
		.collision(collision),
		.game_over(game_over),
		.life_lost(life_lost),
		.start_done(start_done),
		.game_begin(game_begin),
		.game_continue(game_continue),
		.new_level(new_level)
	);

	lives_counter lives_counter_inst (
		.clk_25(clk_25),
		.resetN(resetN),
		.life_lost(life_lost),
		.bonus(bonus),
		.lives(lives),
		.game_over(game_over)
	);

	bcd_score bcd_score_inst (
		.clk_25(clk_25),
		.resetN(resetN),
		.points_add(points_add),
		.points(points),
		.score(score),
		.bonus(bonus)
	);

	// host port
	apb_regs apb_regs_inst (
		.clk_25(clk_25),
		.resetN(resetN),
		.req(apb_req),
		.rsp(apb_rsp),
		.status(status),
		.score(score),
		.points_add(points_add),
		.points(points),
		.collision(collision)
	);

endmodule

// ==== sim/game_ctrl_properties.sv ====
// concurrent checks on the game control core, bound into game_ctrl_top
// failures go out through $error and are counted for the testbench

module game_ctrl_properties (
	input logic clk_25,
	input logic resetN,
	input game_pkg::apb_rsp_t apb_rsp,
	input game_pkg::game_status_t status,
	input logic anim_pulse,
	input logic new_level
);
	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run
	int fail_count = 0;

	// no wait states on the host port
	pready_high: assert property (@(posedge clk_25) disable iff (!resetN) apb_rsp.pready)
		else begin
			fail_count++;
			$error("pready dropped low");
		end

	// game over only with no lives left
	over_means_no_lives: assert property (@(posedge clk_25) disable iff (!resetN)
		status.game_over |-> status.lives == '0)
		else begin
			fail_count++;
			$error("game_over set with lives left");
		end

	// both are single-cycle strobes
	anim_single: assert property (@(posedge clk_25) disable iff (!resetN)
		anim_pulse |=> !anim_pulse)
		else begin
			fail_count++;
			$error("anim_pulse high for two cycles");
		end

	level_single: assert property (@(posedge clk_25) disable iff (!resetN)
		new_level |=> !new_level)
		else begin
			fail_count++;
			$error("new_level high for two cycles");
		end

endmodule

bind game_ctrl_top game_ctrl_properties props (
	.clk_25(clk_25),
	.resetN(resetN),
	.apb_rsp(apb_rsp),
	.status(status),
	.anim_pulse(anim_pulse),
	.new_level(new_level)
);

// ==== sim/game_ctrl_tb.sv ====
// directed testbench for the game control core
// drives vsync and the APB host port, checks against a decimal score and lives model

module game_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk_25;
	logic resetN;
	logic vsync;
	game_pkg::apb_req_t apb_req;
	game_pkg::apb_rsp_t apb_rsp;
	logic anim_pulse;
	game_pkg::anim_phase_t anim_phase;
	logic new_level;
	game_pkg::game_status_t status;

	// reference model state
	int exp_score;
	int exp_lives;
	logic [31:0] lfsr_state = 32'h5240;

	// strobe monitors, sampled mid-cycle
	int anim_count = 0;
	int level_count = 0;
	logic pulse_prev = 1'b0;
	int phase_log[$];

	game_ctrl_top UUT (
		.clk_25(clk_25),
		.resetN(resetN),
		.vsync(vsync),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.anim_pulse(anim_pulse),
		.anim_phase(anim_phase),
		.new_level(new_level),
		.status(status)
	);

	initial begin
		clk_25 = 1'b0;
		forever #10 clk_25 = ~clk_25;
	end

	// phase is logged one cycle after each pulse, once it has stepped
	always @(negedge clk_25) begin
		if (anim_pulse) anim_count++;
		if (new_level) level_count++;
		if (pulse_prev) phase_log.push_back(anim_phase);
		pulse_prev = anim_pulse;
	end

	// ==============================
	// helpers
	// ==============================
	task automatic fail_run(input string what);
		$display("failure at %0t: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
				$time, name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "check failed");
		end
	endtask

	// galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return bits;
	endfunction

	function automatic game_pkg::score_t to_bcd(input int value);
		game_pkg::score_t bcd;
		for (int i = 0; i < game_pkg::SCORE_DIGITS; i++) begin
			bcd[i] = 4'(value % 10);
			value = value / 10;
		end
		return bcd;
	endfunction

	// STATUS layout, lives in 7:4 and the flags below
	function automatic logic [31:0] status_word(input int lives, input logic sd,
			input logic gc, input logic gb, input logic go);
		return {24'b0, 4'(lives), sd, gc, gb, go};
	endfunction

	// ==============================
	// stimulus
	// ==============================
	task automatic apply_reset();
		@(posedge clk_25);
		resetN <= 1'b0;
		vsync <= 1'b0;
		apb_req <= '0;
		repeat (5) @(posedge clk_25);
		resetN <= 1'b1;
		exp_score = 0;
		exp_lives = game_pkg::NUM_LIVES;
	endtask

	// two cycles high, four low
	task automatic pulse_vsync(input int count);
		repeat (count) begin
			@(posedge clk_25);
			vsync <= 1'b1;
			repeat (2) @(posedge clk_25);
			vsync <= 1'b0;
			repeat (3) @(posedge clk_25);
		end
		@(negedge clk_25);
	endtask

	// setup then access, response sampled mid access phase
	task automatic apb_xfer(input logic write, input logic [3:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		int waited;
		@(posedge clk_25);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk_25);
		apb_req.penable <= 1'b1;
		@(negedge clk_25);
		waited = 0;
		while (!apb_rsp.pready) begin
			if (waited == 16) fail_run("pready stayed low during an APB transfer");
			waited++;
			@(negedge clk_25);
		end
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge clk_25);
		apb_req <= '0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			input logic expect_err);
		logic [31:0] rdata;
		logic slverr;
		apb_xfer(1'b1, addr, data, rdata, slverr);
		check_value("pslverr", slverr, expect_err);
	endtask

	task automatic read_reg(input logic [3:0] addr, input string name,
			input logic [31:0] expected);
		logic [31:0] rdata;
		logic slverr;
		apb_xfer(1'b0, addr, '0, rdata, slverr);
		check_value("pslverr", slverr, 1'b0);
		check_value(name, rdata, expected);
	endtask

	// bonus when the low four digits carry into the ten-thousands
	task automatic add_points(input int value);
		if (exp_score % 10000 + value % 10000 >= 10000 && exp_lives < game_pkg::MAX_LIVES)
			exp_lives++;
		exp_score = (exp_score + value) % 1000000;
		write_reg(game_pkg::ADDR_POINTS, to_bcd(value), 1'b0);
		read_reg(game_pkg::ADDR_SCORE, "score", to_bcd(exp_score));
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(exp_lives, 0, 0, 0, 0));
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic check_after_reset();
		@(negedge clk_25);
		check_value("anim_pulse", anim_pulse, 1'b0);
		check_value("new_level", new_level, 1'b0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(3, 0, 0, 0, 0));
		read_reg(game_pkg::ADDR_SCORE, "score", 0);
		// not yet in play, so the hit is ignored
		write_reg(game_pkg::ADDR_COLLIDE, 32'h1, 1'b0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(3, 0, 0, 0, 0));
	endtask

	task automatic check_score_sum();
		int value;
		repeat (12) begin
			value = 0;
			for (int d = 0; d < 4; d++) value = value * 10 + int'(lfsr_bits(4) % 10);
			add_points(value);
		end
		add_points(9999);
	endtask

	task automatic check_bonus_life();
		add_points(9999);
		add_points(1);
		check_value("lives", status.lives, 4);
		// each pair carries out of the thousands digit
		// so lives climb to the cap and stay there
		repeat (8) begin
			add_points(9999);
			add_points(1);
		end
		check_value("lives", status.lives, game_pkg::MAX_LIVES);
	endtask

	task automatic check_sequencing();
		int pulse_base;
		int phase_base;
		int level_base;
		int waited;
		pulse_base = anim_count;
		phase_base = phase_log.size();
		level_base = level_count;
		pulse_vsync(24);
		check_value("anim_pulse count", anim_count - pulse_base, 2);
		pulse_vsync(1);
		check_value("anim_pulse count", anim_count - pulse_base, 3);
		for (int i = 0; i < 3; i++) check_value("anim_phase", phase_log[phase_base + i], 2 - i);
		pulse_vsync(230);
		check_value("start_done", status.start_done, 1'b0);
		pulse_vsync(1);
		check_value("start_done", status.start_done, 1'b1);
		pulse_vsync(255);
		check_value("game_begin", status.game_begin, 1'b0);
		pulse_vsync(1);
		check_value("game_begin", status.game_begin, 1'b1);
		check_value("game_continue", status.game_continue, 1'b1);
		check_value("new_level count", level_count - level_base, 0);
		waited = 0;
		while (level_count == level_base) begin
			if (waited == 4) fail_run("new_level never pulsed after game_begin");
			pulse_vsync(1);
			waited++;
		end
		pulse_vsync(2);
		check_value("new_level count", level_count - level_base, 1);
	endtask

	task automatic check_lives();
		write_reg(game_pkg::ADDR_COLLIDE, 32'h1, 1'b0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(2, 1, 0, 1, 0));
		// wave delay restarts from the middle
		pulse_vsync(255);
		check_value("game_continue", status.game_continue, 1'b0);
		pulse_vsync(1);
		check_value("game_continue", status.game_continue, 1'b1);
		write_reg(game_pkg::ADDR_COLLIDE, 32'h1, 1'b0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(1, 1, 0, 1, 0));
		write_reg(game_pkg::ADDR_COLLIDE, 32'h1, 1'b0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(0, 1, 0, 1, 1));
		write_reg(game_pkg::ADDR_COLLIDE, 32'h1, 1'b0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(0, 1, 0, 1, 1));
	endtask

	task automatic check_bus_errors();
		logic [31:0] rdata;
		logic slverr;
		apb_xfer(1'b0, 4'h2, '0, rdata, slverr);
		check_value("pslverr", slverr, 1'b1);
		write_reg(game_pkg::ADDR_SCORE, 32'h00123456, 1'b1);
		read_reg(game_pkg::ADDR_SCORE, "score", 0);
		read_reg(game_pkg::ADDR_STATUS, "status", status_word(0, 1, 0, 1, 1));
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		resetN = 1'b0;
		vsync = 1'b0;
		apb_req = '0;
		apply_reset();
		check_after_reset();
		check_score_sum();
		apply_reset();
		check_bonus_life();
		apply_reset();
		check_sequencing();
		check_lives();
		check_bus_errors();
		repeat (2) @(posedge clk_25);
		if (UUT.props.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("%0d assertion failures", UUT.props.fail_count);
			$display("ERRORS FOUND");
			$fatal(1, "assertions failed");
		end
	end

endmodule

// ==== src.f ====
design/game_pkg.sv
design/frame_timer.sv
design/wave_sequencer.sv
design/lives_counter.sv
design/bcd_score.sv
design/apb_regs.sv
design/game_ctrl_top.sv
sim/game_ctrl_properties.sv
sim/game_ctrl_tb.sv
